// File: src/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordType;
	typedef logic [4:0] regIndexType;

	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJump = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddiu = 6'h09,
		opLw = 6'h23
	} opcodeType;

	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnSra = 6'h03,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} functType;

	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluSlt} aluOpType;
	typedef enum logic {srcAPc, srcARegA} aluSrcAType;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShift} aluSrcBType;
	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSourceType;
	typedef enum logic {addrPc, addrAluOut} addressSourceType;
	typedef enum logic {destRt, destRd} regDestType;
	typedef enum logic [1:0] {writeAluOut, writeMemData, writeShifter} writeSourceType;

	typedef enum logic [2:0] {
		shiftIdle,
		shiftLoad,
		shiftLeft,
		shiftRightLogical,
		shiftRightArith
	} shiftCommandType;

	// Every strobe and select of the datapath, driven by the FSM
	typedef struct packed {
		logic pcWrite;
		pcSourceType pcSource;
		addressSourceType addressSource;
		logic irWrite;
		logic mdrWrite;
		logic operandWrite;
		aluSrcAType aluSrcA;
		aluSrcBType aluSrcB;
		aluOpType aluOp;
		logic aluOutWrite;
		logic regWrite;
		regDestType regDest;
		writeSourceType writeSource;
		shiftCommandType shiftCommand;
	} controlSignals;

	typedef struct packed {
		opcodeType opcode;
		regIndexType rs;
		regIndexType rt;
		regIndexType rd;
		logic [4:0] shamt;
		functType funct;
	} rFormat;

	typedef struct packed {
		opcodeType opcode;
		regIndexType rs;
		regIndexType rt;
		logic [15:0] imm;
	} iFormat;

	typedef struct packed {
		opcodeType opcode;
		logic [25:0] target;
	} jFormat;

	typedef union packed {
		rFormat r;
		iFormat i;
		jFormat j;
	} instructionWord;

	typedef struct packed {
		logic write;
		regIndexType dest;
		wordType data;
	} regWriteInfo;

endpackage

// File: src/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input logic clock,
	input logic reset,
	input cpuPkg::instructionWord instruction,
	input logic zero,
	output cpuPkg::controlSignals control
);

	typedef enum logic [4:0] {
		resetState,
		fetch,
		fetchWait1,
		fetchWait2,
		decode,
		rTypeExec,
		rTypeWrite,
		addiuExec,
		immWrite,
		shiftPrepare,
		shiftRun,
		shiftWrite,
		branchTarget,
		branchCompare,
		loadAddress,
		loadPresent,
		loadCapture,
		loadWrite,
		jump,
		finish
	} stateType;

	stateType state;
	stateType nextState;

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			state <= resetState;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		control.pcWrite = 1'b0;
		control.pcSource = cpuPkg::pcAluResult;
		control.addressSource = cpuPkg::addrPc;
		control.irWrite = 1'b0;
		control.mdrWrite = 1'b0;
		control.operandWrite = 1'b0;
		control.aluSrcA = cpuPkg::srcAPc;
		control.aluSrcB = cpuPkg::srcBRegB;
		control.aluOp = cpuPkg::aluAdd;
		control.aluOutWrite = 1'b0;
		control.regWrite = 1'b0;
		control.regDest = cpuPkg::destRt;
		control.writeSource = cpuPkg::writeAluOut;
		control.shiftCommand = cpuPkg::shiftIdle;
		nextState = finish;
		case (state)
			resetState: nextState = fetch;
			// PC + 4 goes straight back into the PC
			fetch: begin
				control.pcWrite = 1'b1;
				control.aluSrcB = cpuPkg::srcBFour;
				nextState = fetchWait1;
			end
			fetchWait1: begin
				control.mdrWrite = 1'b1;
				nextState = fetchWait2;
			end
			fetchWait2: begin
				control.irWrite = 1'b1;
				nextState = decode;
			end
			decode: begin
				control.operandWrite = 1'b1;
				case (instruction.r.opcode)
					cpuPkg::opRType: begin
						case (instruction.r.funct)
							cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
							cpuPkg::fnSlt: nextState = rTypeExec;
							cpuPkg::fnSll, cpuPkg::fnSrl,
							cpuPkg::fnSra: nextState = shiftPrepare;
							default: nextState = finish;
						endcase
					end
					cpuPkg::opAddiu: nextState = addiuExec;
					cpuPkg::opBeq, cpuPkg::opBne: nextState = branchTarget;
					cpuPkg::opLw: nextState = loadAddress;
					cpuPkg::opJump: nextState = jump;
					default: nextState = finish;
				endcase
			end
			rTypeExec: begin
				control.aluSrcA = cpuPkg::srcARegA;
				control.aluOutWrite = 1'b1;
				case (instruction.r.funct)
					cpuPkg::fnSub: control.aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: control.aluOp = cpuPkg::aluAnd;
					cpuPkg::fnSlt: control.aluOp = cpuPkg::aluSlt;
					default: control.aluOp = cpuPkg::aluAdd;
				endcase
				nextState = rTypeWrite;
			end
			rTypeWrite: begin
				control.regWrite = 1'b1;
				control.regDest = cpuPkg::destRd;
			end
			addiuExec, loadAddress: begin
				control.aluSrcA = cpuPkg::srcARegA;
				control.aluSrcB = cpuPkg::srcBImm;
				control.aluOutWrite = 1'b1;
				nextState = (state == addiuExec) ? immWrite : loadPresent;
			end
			immWrite: control.regWrite = 1'b1;
			shiftPrepare: begin
				control.shiftCommand = cpuPkg::shiftLoad;
				nextState = shiftRun;
			end
			shiftRun: begin
				case (instruction.r.funct)
					cpuPkg::fnSrl: control.shiftCommand = cpuPkg::shiftRightLogical;
					cpuPkg::fnSra: control.shiftCommand = cpuPkg::shiftRightArith;
					default: control.shiftCommand = cpuPkg::shiftLeft;
				endcase
				nextState = shiftWrite;
			end
			shiftWrite: begin
				control.regWrite = 1'b1;
				control.regDest = cpuPkg::destRd;
				control.writeSource = cpuPkg::writeShifter;
			end
			// Target is parked in ALUOut while A - B sets the zero flag
			branchTarget: begin
				control.aluSrcB = cpuPkg::srcBImmShift;
				control.aluOutWrite = 1'b1;
				nextState = branchCompare;
			end
			branchCompare: begin
				control.aluSrcA = cpuPkg::srcARegA;
				control.aluOp = cpuPkg::aluSub;
				control.pcSource = cpuPkg::pcAluOut;
				control.pcWrite = (instruction.i.opcode == cpuPkg::opBeq) ? zero : !zero;
			end
			loadPresent: begin
				control.addressSource = cpuPkg::addrAluOut;
				nextState = loadCapture;
			end
			loadCapture: begin
				control.addressSource = cpuPkg::addrAluOut;
				control.mdrWrite = 1'b1;
				nextState = loadWrite;
			end
			loadWrite: begin
				control.regWrite = 1'b1;
				control.writeSource = cpuPkg::writeMemData;
			end
			jump: begin
				control.pcWrite = 1'b1;
				control.pcSource = cpuPkg::pcJump;
			end
			default: nextState = fetch;
		endcase
	end

endmodule

// File: src/instructionFetch.sv
`timescale 1ns/10ps

module instructionFetch #(
	parameter cpuPkg::wordType resetAddress = '0
) (
	input logic clock,
	input logic reset,
	input cpuPkg::controlSignals control,
	input cpuPkg::wordType aluResult,
	input cpuPkg::wordType aluOut,
	input cpuPkg::wordType memReadData,
	output cpuPkg::instructionWord instruction,
	output cpuPkg::wordType pc,
	output cpuPkg::wordType memData,
	output cpuPkg::wordType memAddress
);

	cpuPkg::wordType nextPc;
	cpuPkg::wordType jumpTarget;

	// Upper bits come from the already incremented PC
	assign jumpTarget = {pc[31:28], instruction.j.target, 2'b00};

	always_comb begin
		case (control.pcSource)
			cpuPkg::pcAluOut: nextPc = aluOut;
			cpuPkg::pcJump: nextPc = jumpTarget;
			default: nextPc = aluResult;
		endcase
	end

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			pc <= resetAddress;
		end else if (control.pcWrite) begin
			pc <= nextPc;
		end
	end

	// All reads land in the MDR first, instructions included
	always_ff @(posedge clock) begin
		if (control.mdrWrite) begin
			memData <= memReadData;
		end
	end

	always_ff @(posedge clock) begin
		if (control.irWrite) begin
			instruction <= memData;
		end
	end

	assign memAddress = (control.addressSource == cpuPkg::addrAluOut) ? aluOut : pc;

endmodule

// File: src/registerFile.sv
`timescale 1ns/10ps

module registerFile (
	input logic clock,
	input logic reset,
	input cpuPkg::controlSignals control,
	input cpuPkg::instructionWord instruction,
	input cpuPkg::wordType aluOut,
	input cpuPkg::wordType memData,
	input cpuPkg::wordType shiftResult,
	output cpuPkg::wordType readA,
	output cpuPkg::wordType readB,
	output cpuPkg::regWriteInfo writeInfo
);

	// No storage behind register zero
	cpuPkg::wordType registers [1:31];

	assign readA = (instruction.r.rs == '0) ? '0 : registers[instruction.r.rs];
	assign readB = (instruction.r.rt == '0) ? '0 : registers[instruction.r.rt];

	assign writeInfo.write = control.regWrite;
	assign writeInfo.dest = (control.regDest == cpuPkg::destRd) ? instruction.r.rd
		: instruction.i.rt;

	always_comb begin
		case (control.writeSource)
			cpuPkg::writeMemData: writeInfo.data = memData;
			cpuPkg::writeShifter: writeInfo.data = shiftResult;
			default: writeInfo.data = aluOut;
		endcase
	end

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			for (int index = 1; index < 32; index++) begin
				registers[index] <= '0;
			end
		end else if (writeInfo.write && writeInfo.dest != '0) begin
			registers[writeInfo.dest] <= writeInfo.data;
		end
	end

endmodule

// File: src/executeUnit.sv
`timescale 1ns/10ps

module executeUnit (
	input logic clock,
	input logic reset,
	input cpuPkg::controlSignals control,
	input cpuPkg::instructionWord instruction,
	input cpuPkg::wordType pc,
	input cpuPkg::wordType readA,
	input cpuPkg::wordType readB,
	output cpuPkg::wordType operandB,
	output cpuPkg::wordType aluResult,
	output cpuPkg::wordType aluOut,
	output logic zero
);

	cpuPkg::wordType operandA;
	cpuPkg::wordType signExtended;
	cpuPkg::wordType aluA;
	cpuPkg::wordType aluB;

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			operandA <= '0;
			operandB <= '0;
		end else if (control.operandWrite) begin
			operandA <= readA;
			operandB <= readB;
		end
	end

	assign signExtended = {{16{instruction.i.imm[15]}}, instruction.i.imm};
	assign aluA = (control.aluSrcA == cpuPkg::srcARegA) ? operandA : pc;

	always_comb begin
		case (control.aluSrcB)
			cpuPkg::srcBFour: aluB = 32'd4;
			cpuPkg::srcBImm: aluB = signExtended;
			// Branch offsets count words
			cpuPkg::srcBImmShift: aluB = {signExtended[29:0], 2'b00};
			default: aluB = operandB;
		endcase
	end

	always_comb begin
		case (control.aluOp)
			cpuPkg::aluSub: aluResult = aluA - aluB;
			cpuPkg::aluAnd: aluResult = aluA & aluB;
			cpuPkg::aluSlt: aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
			default: aluResult = aluA + aluB;
		endcase
	end

	assign zero = (aluResult == '0);

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			aluOut <= '0;
		end else if (control.aluOutWrite) begin
			aluOut <= aluResult;
		end
	end

endmodule

// File: src/shifter.sv
`timescale 1ns/10ps

module shifter (
	input logic clock,
	input logic reset,
	input cpuPkg::controlSignals control,
	input cpuPkg::instructionWord instruction,
	input cpuPkg::wordType operandB,
	output cpuPkg::wordType shiftResult
);

	cpuPkg::wordType shifted;
	logic [4:0] amount;

	assign amount = instruction.r.shamt;

	always_comb begin
		case (control.shiftCommand)
			cpuPkg::shiftLoad: shifted = operandB;
			cpuPkg::shiftLeft: shifted = shiftResult << amount;
			cpuPkg::shiftRightLogical: shifted = shiftResult >> amount;
			// Sign bit fills from the left
			cpuPkg::shiftRightArith: shifted = $signed(shiftResult) >>> amount;
			default: shifted = shiftResult;
		endcase
	end

	always_ff @(posedge clock, posedge reset) begin
		if (reset) begin
			shiftResult <= '0;
		end else begin
			shiftResult <= shifted;
		end
	end

endmodule

// File: src/cpuTop.sv
`timescale 1ns/10ps

module cpuTop #(
	parameter cpuPkg::wordType resetAddress = '0
) (
	input logic clock,
	input logic reset,
	output cpuPkg::wordType memAddress,
	input cpuPkg::wordType memReadData,
	output cpuPkg::regWriteInfo writeInfo
);

	cpuPkg::controlSignals control;
	cpuPkg::instructionWord instruction;
	cpuPkg::wordType pc;
	cpuPkg::wordType memData;
	cpuPkg::wordType aluResult;
	cpuPkg::wordType aluOut;
	cpuPkg::wordType operandB;
	cpuPkg::wordType readA;
	cpuPkg::wordType readB;
	cpuPkg::wordType shiftResult;
	logic zero;

	controlUnit controlInst (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.zero(zero),
		.control(control)
	);

	instructionFetch #(
		.resetAddress(resetAddress)
	) fetchInst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.aluResult(aluResult),
		.aluOut(aluOut),
		.memReadData(memReadData),
		.instruction(instruction),
		.pc(pc),
		.memData(memData),
		.memAddress(memAddress)
	);

	registerFile registersInst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.instruction(instruction),
		.aluOut(aluOut),
		.memData(memData),
		.shiftResult(shiftResult),
		.readA(readA),
		.readB(readB),
		.writeInfo(writeInfo)
	);

	executeUnit executeInst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.instruction(instruction),
		.pc(pc),
		.readA(readA),
		.readB(readB),
		.operandB(operandB),
		.aluResult(aluResult),
		.aluOut(aluOut),
		.zero(zero)
	);

	shifter shifterInst (
		.clock(clock),
		.reset(reset),
		.control(control),
		.instruction(instruction),
		.operandB(operandB),
		.shiftResult(shiftResult)
	);

endmodule

// File: verif/cpuTests.svh
function automatic cpuPkg::wordType rTypeWord(input logic [5:0] funct, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
	return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic cpuPkg::wordType iTypeWord(input logic [5:0] opcode, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {opcode, rs, rt, imm};
endfunction

function automatic cpuPkg::wordType jTypeWord(input cpuPkg::wordType target);
	return {6'h02, target[27:2]};
endfunction

function automatic cpuPkg::wordType randomWord();
	cpuPkg::wordType value;
	value = $random(seed);
	return value;
endfunction

task automatic enterReset();
	@(negedge clock);
	reset = 1'b1;
	for (int index = 0; index < 256; index++) begin
		memory[index] = {16'hdead, 6'b0, index[7:0], 2'b00};
	end
endtask

task automatic putInstruction(input int index, input cpuPkg::wordType word);
	cpuPkg::wordType address;
	address = resetAddress + (cpuPkg::wordType'(index) << 2);
	memory[address[9:2]] = word;
endtask

// Holds reset 2 cycles and returns in the first fetch cycle
task automatic releaseReset();
	repeat (2) @(negedge clock);
	reset = 1'b0;
	for (int index = 0; index < 32; index++) begin
		expectedRegs[index] = '0;
	end
	@(negedge clock);
endtask

// Expected timing and result of one instruction
task automatic predictInstruction(input cpuPkg::wordType address, input cpuPkg::wordType word,
	output int cycles, output int writeAt, output logic [4:0] dest,
	output cpuPkg::wordType data, output int loadAt, output cpuPkg::wordType loadAddress,
	output cpuPkg::wordType nextAddress);
	cpuPkg::wordType a;
	cpuPkg::wordType b;
	cpuPkg::wordType ext;
	cpuPkg::wordType nextPc;
	a = expectedRegs[word[25:21]];
	b = expectedRegs[word[20:16]];
	ext = {{16{word[15]}}, word[15:0]};
	nextPc = address + 32'd4;
	cycles = 5;
	writeAt = -1;
	dest = word[20:16];
	data = '0;
	loadAt = -1;
	loadAddress = '0;
	nextAddress = nextPc;
	case (word[31:26])
		cpuPkg::opRType: begin
			dest = word[15:11];
			case (word[5:0])
				cpuPkg::fnAdd: data = a + b;
				cpuPkg::fnSub: data = a - b;
				cpuPkg::fnAnd: data = a & b;
				cpuPkg::fnSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				cpuPkg::fnSll: data = b << word[10:6];
				cpuPkg::fnSrl: data = b >> word[10:6];
				cpuPkg::fnSra: data = $signed(b) >>> word[10:6];
				default: data = '0;
			endcase
			if (word[5:0] inside {cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnSlt}) begin
				cycles = 7;
				writeAt = 5;
			end else if (word[5:0] inside {cpuPkg::fnSll, cpuPkg::fnSrl, cpuPkg::fnSra}) begin
				cycles = 8;
				writeAt = 6;
			end
		end
		cpuPkg::opAddiu: begin
			cycles = 7;
			writeAt = 5;
			data = a + ext;
		end
		cpuPkg::opBeq, cpuPkg::opBne: begin
			cycles = 7;
			if ((a == b) == (word[31:26] == cpuPkg::opBeq)) begin
				nextAddress = nextPc + (ext << 2);
			end
		end
		cpuPkg::opLw: begin
			cycles = 9;
			writeAt = 7;
			loadAt = 5;
			loadAddress = a + ext;
			data = memory[loadAddress[9:2]];
		end
		cpuPkg::opJump: begin
			cycles = 6;
			nextAddress = {nextPc[31:28], word[25:0], 2'b00};
		end
		default: cycles = 5;
	endcase
	if (writeAt > 0 && dest != 5'd0) begin
		expectedRegs[dest] = data;
	end
endtask

task automatic checkFetch(input cpuPkg::wordType address);
	assert (memAddress == address) else stopOnError($sformatf(
		"CHECK FAILED at time %0t: fetch address %h, expected %h", $time, memAddress, address));
endtask

// Starts in a fetch cycle and ends in the next one
task automatic stepInstruction(input cpuPkg::wordType address, input int cycles,
	input int writeAt, input logic [4:0] dest, input cpuPkg::wordType data,
	input int loadAt, input cpuPkg::wordType loadAddress);
	checkFetch(address);
	for (int step = 1; step < cycles; step++) begin
		@(negedge clock);
		assert (writeInfo.write == (step == writeAt)) else stopOnError($sformatf(
			"CHECK FAILED at time %0t: write strobe %b in cycle %0d of instruction at %h",
			$time, writeInfo.write, step, address));
		if (step == writeAt) begin
			assert (writeInfo.dest == dest && writeInfo.data == data) else stopOnError($sformatf(
				"CHECK FAILED at time %0t: write r%0d = %h, expected r%0d = %h",
				$time, writeInfo.dest, writeInfo.data, dest, data));
		end
		if (step == loadAt || (loadAt > 0 && step == loadAt + 1)) begin
			assert (memAddress == loadAddress) else stopOnError($sformatf(
				"CHECK FAILED at time %0t: data address %h, expected %h",
				$time, memAddress, loadAddress));
		end
	end
	@(negedge clock);
endtask

task automatic runProgram(input int count);
	cpuPkg::wordType address;
	cpuPkg::wordType word;
	cpuPkg::wordType data;
	cpuPkg::wordType loadAddress;
	cpuPkg::wordType nextAddress;
	int cycles;
	int writeAt;
	int loadAt;
	logic [4:0] dest;
	address = resetAddress;
	for (int n = 0; n < count; n++) begin
		word = memory[address[9:2]];
		predictInstruction(address, word, cycles, writeAt, dest, data, loadAt, loadAddress,
			nextAddress);
		stepInstruction(address, cycles, writeAt, dest, data, loadAt, loadAddress);
		address = nextAddress;
	end
	checkFetch(address);
endtask

task automatic fetchSequence();
	enterReset();
	for (int index = 0; index < 4; index++) begin
		putInstruction(index, rTypeWord(cpuPkg::fnAdd, 5'd0, 5'd0, 5'(index + 1), 5'd0));
	end
	releaseReset();
	runProgram(4);
endtask

task automatic arithmeticOps();
	cpuPkg::wordType value1;
	cpuPkg::wordType value2;
	cpuPkg::wordType value3;
	value1 = randomWord();
	value2 = randomWord();
	value3 = randomWord();
	enterReset();
	// Operands of opposite sign tell a signed compare from an unsigned one
	putInstruction(0, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd1, value1[15:0] | 16'h8000));
	putInstruction(1, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd2, value2[15:0] & 16'h7fff));
	putInstruction(2, iTypeWord(cpuPkg::opAddiu, 5'd1, 5'd3, value3[15:0]));
	putInstruction(3, rTypeWord(cpuPkg::fnAdd, 5'd1, 5'd2, 5'd4, 5'd0));
	putInstruction(4, rTypeWord(cpuPkg::fnSub, 5'd1, 5'd2, 5'd5, 5'd0));
	putInstruction(5, rTypeWord(cpuPkg::fnAnd, 5'd1, 5'd3, 5'd6, 5'd0));
	putInstruction(6, rTypeWord(cpuPkg::fnSlt, 5'd1, 5'd2, 5'd7, 5'd0));
	putInstruction(7, rTypeWord(cpuPkg::fnSlt, 5'd2, 5'd1, 5'd8, 5'd0));
	putInstruction(8, rTypeWord(cpuPkg::fnSub, 5'd0, 5'd3, 5'd9, 5'd0));
	// Large unsigned sums wrap
	putInstruction(9, rTypeWord(cpuPkg::fnAdd, 5'd1, 5'd1, 5'd10, 5'd0));
	releaseReset();
	runProgram(10);
endtask

task automatic shiftOps();
	cpuPkg::wordType amounts;
	amounts = randomWord();
	enterReset();
	memory[8'hc0] = randomWord();
	memory[8'hc1] = randomWord() | 32'h8000_0000;
	putInstruction(0, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd1, 16'h0300));
	putInstruction(1, iTypeWord(cpuPkg::opLw, 5'd1, 5'd2, 16'h0000));
	putInstruction(2, iTypeWord(cpuPkg::opLw, 5'd1, 5'd3, 16'h0004));
	putInstruction(3, rTypeWord(cpuPkg::fnSll, 5'd0, 5'd2, 5'd4, amounts[4:0] | 5'd1));
	putInstruction(4, rTypeWord(cpuPkg::fnSrl, 5'd0, 5'd3, 5'd5, amounts[9:5] | 5'd1));
	putInstruction(5, rTypeWord(cpuPkg::fnSra, 5'd0, 5'd3, 5'd6, amounts[14:10] | 5'd1));
	putInstruction(6, rTypeWord(cpuPkg::fnSra, 5'd0, 5'd2, 5'd7, amounts[19:15]));
	releaseReset();
	runProgram(7);
endtask

task automatic wordLoads();
	enterReset();
	for (int index = 8'hc4; index < 8'hd0; index++) begin
		memory[index] = randomWord();
	end
	putInstruction(0, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd1, 16'h0320));
	putInstruction(1, iTypeWord(cpuPkg::opLw, 5'd1, 5'd2, 16'hfff8));
	putInstruction(2, iTypeWord(cpuPkg::opLw, 5'd1, 5'd3, 16'h000c));
	putInstruction(3, iTypeWord(cpuPkg::opLw, 5'd1, 5'd4, 16'h0000));
	putInstruction(4, iTypeWord(cpuPkg::opAddiu, 5'd1, 5'd5, 16'hfff0));
	putInstruction(5, iTypeWord(cpuPkg::opLw, 5'd5, 5'd6, 16'h0004));
	releaseReset();
	runProgram(6);
endtask

task automatic branchesAndJump();
	enterReset();
	putInstruction(0, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd1, 16'd5));
	putInstruction(1, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd2, 16'd5));
	putInstruction(2, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd3, 16'd7));
	putInstruction(3, iTypeWord(cpuPkg::opBeq, 5'd1, 5'd2, 16'd2));
	putInstruction(6, iTypeWord(cpuPkg::opBne, 5'd1, 5'd2, 16'd5));
	putInstruction(7, iTypeWord(cpuPkg::opBeq, 5'd1, 5'd3, 16'd5));
	putInstruction(8, iTypeWord(cpuPkg::opBne, 5'd1, 5'd3, 16'd2));
	putInstruction(9, jTypeWord(resetAddress + 32'd52));
	// Taken backward branch lands on the jump
	putInstruction(11, iTypeWord(cpuPkg::opBeq, 5'd1, 5'd2, 16'hfffd));
	putInstruction(13, rTypeWord(cpuPkg::fnAdd, 5'd1, 5'd3, 5'd4, 5'd0));
	releaseReset();
	runProgram(10);
endtask

task automatic registerZeroAndUnknown();
	cpuPkg::wordType value;
	value = randomWord();
	enterReset();
	putInstruction(0, iTypeWord(cpuPkg::opAddiu, 5'd0, 5'd0, value[15:0] | 16'h0001));
	putInstruction(1, rTypeWord(cpuPkg::fnAdd, 5'd0, 5'd0, 5'd5, 5'd0));
	putInstruction(2, rTypeWord(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
	putInstruction(3, iTypeWord(6'h3f, 5'd1, 5'd2, 16'h1234));
	putInstruction(4, rTypeWord(cpuPkg::fnAdd, 5'd0, 5'd5, 5'd6, 5'd0));
	releaseReset();
	runProgram(5);
endtask

// File: verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

	localparam cpuPkg::wordType resetAddress = 32'h0000_0100;
	// About 50 instructions of at most 9 cycles, plus resets, with margin
	localparam int timeoutCycles = 2000;

	logic clock;
	logic reset;
	cpuPkg::wordType memAddress;
	cpuPkg::wordType memReadData;
	cpuPkg::regWriteInfo writeInfo;

	// Word memory, decoded on address bits 9 to 2
	cpuPkg::wordType memory [0:255];
	cpuPkg::wordType sampledAddress;
	cpuPkg::wordType expectedRegs [0:31];
	integer seed;
	int cycleCount;

	cpuTop #(
		.resetAddress(resetAddress)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.memAddress(memAddress),
		.memReadData(memReadData),
		.writeInfo(writeInfo)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Address taken at the rising edge, data out at the falling edge
	always @(posedge clock) begin
		sampledAddress <= memAddress;
	end

	always @(negedge clock) begin
		memReadData <= memory[sampledAddress[9:2]];
	end

	task automatic stopOnError(input string message);
		$display("%s", message);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			stopOnError($sformatf("Timeout: the tests did not finish within %0d clock cycles",
				timeoutCycles));
		end
	end

	`include "cpuTests.svh"

	initial begin
		reset = 1'b1;
		memReadData = '0;
		sampledAddress = '0;
		cycleCount = 0;
		seed = 32'h033097f2;
		fetchSequence();
		arithmeticOps();
		shiftOps();
		wordLoads();
		branchesAndJump();
		registerZeroAndUnknown();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: all.f
+incdir+verif
src/cpuPkg.sv
src/controlUnit.sv
src/instructionFetch.sv
src/registerFile.sv
src/executeUnit.sv
src/shifter.sv
src/cpuTop.sv
verif/cpuTb.sv

// File: Makefile
# Verilator build and run of the CPU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the simulation with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f all.f --top-module cpuTb -o cpuSim
	./obj_dir/cpuSim

clean:
	rm -rf obj_dir
